//--- tb/prog.hex
// one 16-bit word per line from address 0
// high byte op[7:5] dev[4:1] reg[0], low byte immediate or zero page address
1602 // wait for tx side
0C00
065A // constant out
0210 // mar low
00A5
013C // x
6020 // x into zero page 20
1609
0C07
2600 // read back through mar
4620 // read back zero page
01C8
0364
160F
0C0D
A601 // x+y to uart and y
1212 // jmpc
06BD
06C1
1015 // jmpz, not taken
067E
1417 // echo loop
0C15
C100 // rx byte into x
161A
0C18
A606 // x+1 out
0C15

//--- build.f
src/cpu_pkg.sv
src/control.sv
src/program_counter.sv
src/alu_regs.sv
src/data_ram.sv
src/uart_port.sv
src/cpu_top.sv
tb/clock_gen.sv
tb/cpu_tb.sv

//--- run_sim.sh
#!/bin/sh
# compile the cpu testbench with verilator, run it, then search the log

top=cpu_tb
obj=obj_dir
log=sim.log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module "$top" \
    -f build.f --Mdir "$obj" -o "$top"
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

"./$obj/$top" > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^Finished with no errors$" "$log"; then
    exit 0
fi
exit 1

//--- tb/cpu_tb.sv
`timescale 1ns/1ps
module cpu_tb
    import cpu_pkg::*;
();

    localparam int n_echo = 60;                     // random bytes in the echo test
    localparam int max_cycles = 200 + n_echo * 30;  // fixed sections, then worst echo

    logic              clk;
    logic              rst;
    logic [data_w-1:0] rx_data;
    logic              rx_strobe;
    logic              tx_ready;
    logic [data_w-1:0] tx_data;
    logic              tx_strobe;

    logic [data_w-1:0] expected [$];    // bytes still due on tx
    logic [data_w-1:0] exp_byte;
    logic [31:0]       lcg_state;
    logic              ready_at_edge;   // tx_ready as the write edge saw it
    int                seen = 0;
    int                errors = 0;
    int                cycle_count = 0;
    int                tests_run = 0;
    int                tests_failed = 0;

    clock_gen clk0 (.clk, .rst);

    cpu_top dut0 (
        .clk, .rst, .rx_data, .rx_strobe, .tx_ready, .tx_data, .tx_strobe
    );

    function automatic logic [31:0] next_random();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    task automatic wait_bytes(input int target);
        while (seen < target)
            @(posedge clk);
    endtask

    task automatic report_section(input string name, input int errors_before);
        tests_run++;
        if (errors == errors_before) begin
            $display("%s: ok", name);
        end else begin
            tests_failed++;
            $display("%s: %0d errors", name, errors - errors_before);
        end
    endtask

    always @(posedge clk) begin
        ready_at_edge <= tx_ready;
        cycle_count <= cycle_count + 1;
    end

    // outputs have settled by the falling edge
    always @(negedge clk) begin
        if (rst) begin
            assert (!tx_strobe)
                else begin
                    $display("tx_strobe high during reset at %0t", $time);
                    errors++;
                end
        end else if (tx_strobe) begin
            seen++;
            assert (ready_at_edge)
                else begin
                    $display("tx byte %02h sent while tx_ready was low at %0t", tx_data, $time);
                    errors++;
                end
            assert (expected.size() > 0)
                else begin
                    $display("tx byte %02h at %0t with no byte expected", tx_data, $time);
                    errors++;
                end
            if (expected.size() > 0) begin
                exp_byte = expected.pop_front();
                assert (tx_data == exp_byte)
                    else begin
                        $display("Mismatch at %0t: tx_data is %02h, expected %02h",
                                 $time, tx_data, exp_byte);
                        errors++;
                    end
            end
        end
    end

    initial begin
        wait (cycle_count >= max_cycles);
        $display("timeout after %0d cycles, %0d tx bytes never arrived",
                 cycle_count, expected.size());
        $display("Finished with errors");
        $finish;
    end

    initial begin
        int                errors_before;
        logic [31:0]       r;
        logic [data_w-1:0] b;
        int                span;

        lcg_state = 32'hc16a;
        rx_data = '0;
        rx_strobe = 1'b0;
        tx_ready = 1'b1;

        // fixed sections in program order
        expected.push_back(8'h5a);              // immediate to uart
        expected.push_back(8'ha5);              // stored through mar
        expected.push_back(8'h3c);              // stored through zero page
        expected.push_back(8'(200 + 100));      // carry out dropped
        expected.push_back(8'hc1);              // jmpc taken
        expected.push_back(8'h7e);              // jmpz fell through

        errors_before = errors;
        @(negedge rst);
        report_section("reset, tx quiet", errors_before);

        errors_before = errors;
        wait_bytes(1);
        report_section("immediate to uart", errors_before);

        errors_before = errors;
        wait_bytes(3);
        report_section("ram via mar and zero page", errors_before);

        errors_before = errors;
        wait_bytes(6);
        report_section("alu add and flag jumps", errors_before);

        // receiver busy while each byte goes in, then free for the echo
        errors_before = errors;
        for (int i = 0; i < n_echo; i++) begin
            @(posedge clk);
            #1;
            tx_ready = 1'b0;
            r = next_random();
            b = r[23:16];
            span = 1 + int'(r[10:8]);
            expected.push_back(8'(b + 8'd1));
            assert (dut0.uart_in_ready_n)
                else begin
                    $display("rx byte offered at %0t while receive register full", $time);
                    errors++;
                end
            rx_data = b;
            rx_strobe = 1'b1;
            @(posedge clk);
            #1;
            rx_strobe = 1'b0;
            repeat (span) @(posedge clk);
            #1;
            tx_ready = 1'b1;
            wait_bytes(7 + i);
        end
        report_section("uart echo with back-pressure", errors_before);

        $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule : cpu_tb

//--- tb/clock_gen.sv
`timescale 1ns/1ps
module clock_gen (
    output logic clk,
    output logic rst
);

    localparam int half_period = 20;    // 40 ns clock
    localparam int reset_cycles = 8;

    initial begin
        clk = 1'b0;
        forever #(half_period) clk = !clk;
    end

    initial begin
        rst = 1'b1;
        repeat (reset_cycles) @(posedge clk);
        #1 rst = 1'b0;                  // released just after the 8th edge
    end

endmodule : clock_gen

//--- src/cpu_top.sv
`timescale 1ns/1ps
module cpu_top
    import cpu_pkg::*;
(
    input  logic              clk,
    input  logic              rst,
    input  logic [data_w-1:0] rx_data,
    input  logic              rx_strobe,
    input  logic              tx_ready,
    output logic [data_w-1:0] tx_data,
    output logic              tx_strobe
);

    logic [instr_w-1:0] instr;
    logic [data_w-1:0]  imm;
    logic [data_w-1:0]  bus;
    logic [data_w-1:0]  ram_rdata;
    logic [data_w-1:0]  alu_result;
    logic [data_w-1:0]  rx_byte;

    logic rom_out_n, ram_out_n, alu_out_n, uart_out_n;
    logic ram_in_n, marlo_in_n, marhi_in_n, uart_in_n;
    logic pchitmp_in_n, pclo_in_n, pc_in_n, reg_in_n, reg_sel;
    logic force_alu_op_to_passx, force_x_val_to_zero_n, ram_zp_n;
    logic flag_z_n, flag_c_n, flag_o_n, flag_eq_n, flag_ne_n, flag_gt_n, flag_lt_n;
    logic uart_in_ready_n, uart_out_ready_n;

    assign imm = instr[data_w-1:0];

    // single driver on the data bus
    always_comb begin
        if (!rom_out_n)
            bus = imm;
        else if (!ram_out_n)
            bus = ram_rdata;
        else if (!alu_out_n)
            bus = alu_result;
        else if (!uart_out_n)
            bus = rx_byte;
        else
            bus = '0;
    end

    control ctrl0 (
        .hi_rom(instr[instr_w-1:data_w]),
        .flag_z_n, .flag_c_n, .flag_o_n, .flag_eq_n, .flag_ne_n, .flag_gt_n, .flag_lt_n,
        .uart_in_ready_n, .uart_out_ready_n,
        .rom_out_n, .ram_out_n, .alu_out_n, .uart_out_n,
        .ram_in_n, .marlo_in_n, .marhi_in_n, .uart_in_n,
        .pchitmp_in_n, .pclo_in_n, .pc_in_n, .reg_in_n, .reg_sel,
        .force_alu_op_to_passx, .force_x_val_to_zero_n, .ram_zp_n
    );

    program_counter pc0 (
        .clk, .rst, .bus, .pchitmp_in_n, .pclo_in_n, .pc_in_n, .instr
    );

    alu_regs alu0 (
        .clk, .rst, .bus,
        .alu_op(imm[3:0]),              // op nibble of the immediate
        .reg_in_n, .reg_sel, .alu_out_n, .force_alu_op_to_passx, .force_x_val_to_zero_n,
        .result(alu_result),
        .flag_z_n, .flag_c_n, .flag_o_n, .flag_eq_n, .flag_ne_n, .flag_gt_n, .flag_lt_n
    );

    data_ram ram0 (
        .clk, .rst, .bus, .zp_addr(imm),
        .ram_in_n, .marlo_in_n, .marhi_in_n, .ram_zp_n,
        .rdata(ram_rdata)
    );

    uart_port uart0 (
        .clk, .rst, .bus, .uart_in_n, .uart_out_n,
        .rx_data, .rx_strobe, .tx_ready,
        .rx_byte, .tx_data, .tx_strobe, .uart_in_ready_n, .uart_out_ready_n
    );

endmodule : cpu_top

//--- src/uart_port.sv
`timescale 1ns/1ps
module uart_port
    import cpu_pkg::*;
(
    input  logic              clk,
    input  logic              rst,
    input  logic [data_w-1:0] bus,
    input  logic              uart_in_n,    // cpu writes tx byte
    input  logic              uart_out_n,   // cpu reads rx byte
    input  logic [data_w-1:0] rx_data,
    input  logic              rx_strobe,
    input  logic              tx_ready,
    output logic [data_w-1:0] rx_byte,
    output logic [data_w-1:0] tx_data,
    output logic              tx_strobe,
    output logic              uart_in_ready_n,
    output logic              uart_out_ready_n
);

    logic              rx_full_q;
    logic [data_w-1:0] rx_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            rx_full_q <= 1'b0;
            tx_strobe <= 1'b0;
        end else begin
            if (rx_strobe && !rx_full_q)
                rx_full_q <= 1'b1;          // offer while full is dropped
            else if (!uart_out_n)
                rx_full_q <= 1'b0;
            tx_strobe <= !uart_in_n;        // one cycle per write
        end
    end

    always_ff @(posedge clk) begin
        if (rx_strobe && !rx_full_q)
            rx_q <= rx_data;
        if (!uart_in_n)
            tx_data <= bus;
    end

    assign rx_byte = rx_q;
    assign uart_in_ready_n = !rx_full_q;
    assign uart_out_ready_n = !tx_ready;

    a_no_read_empty: assert property (@(posedge clk) disable iff (rst)
        !uart_out_n |-> rx_full_q)
        else $error("uart_port: rx read while empty");

    // program must poll jmpdo first, else the pending byte is lost downstream
    a_no_write_busy: assert property (@(posedge clk) disable iff (rst)
        !uart_in_n |-> tx_ready)
        else $error("uart_port: tx write while receiver not ready");

endmodule : uart_port

//--- src/data_ram.sv
`timescale 1ns/1ps
module data_ram
    import cpu_pkg::*;
(
    input  logic              clk,
    input  logic              rst,
    input  logic [data_w-1:0] bus,
    input  logic [data_w-1:0] zp_addr,      // immediate byte
    input  logic              ram_in_n,
    input  logic              marlo_in_n,
    input  logic              marhi_in_n,
    input  logic              ram_zp_n,
    output logic [data_w-1:0] rdata
);

    logic [data_w-1:0] marlo_q;
    logic [data_w-1:0] marhi_q;
    logic [data_w-1:0] addr;
    logic [data_w-1:0] mem [ram_depth];

    always_ff @(posedge clk) begin
        if (rst) begin
            marlo_q <= '0;
            marhi_q <= '0;
        end else begin
            if (!marlo_in_n)
                marlo_q <= bus;
            if (!marhi_in_n)
                marhi_q <= bus;
        end
    end

    // zero page takes the immediate, high byte ignored
    assign addr = ram_zp_n ? marlo_q : zp_addr;

    always_ff @(posedge clk) begin
        if (!ram_in_n)
            mem[addr] <= bus;
    end

    assign rdata = mem[addr];

    // only page 0 exists behind the mar
    a_mar_page0: assert property (@(posedge clk) disable iff (rst)
        (!ram_in_n && ram_zp_n) |-> (marhi_q == '0))
        else $error("data_ram: write through mar page %02h", marhi_q);

endmodule : data_ram

//--- src/alu_regs.sv
`timescale 1ns/1ps
module alu_regs
    import cpu_pkg::*;
(
    input  logic              clk,
    input  logic              rst,
    input  logic [data_w-1:0] bus,
    input  logic [3:0]        alu_op,
    input  logic              reg_in_n,
    input  logic              reg_sel,
    input  logic              alu_out_n,
    input  logic              force_alu_op_to_passx,
    input  logic              force_x_val_to_zero_n,
    output logic [data_w-1:0] result,
    output logic              flag_z_n,
    output logic              flag_c_n,
    output logic              flag_o_n,
    output logic              flag_eq_n,
    output logic              flag_ne_n,
    output logic              flag_gt_n,
    output logic              flag_lt_n
);

    logic [data_w-1:0] x_q;
    logic [data_w-1:0] y_q;
    logic [data_w-1:0] a;
    logic [data_w-1:0] b;
    logic [3:0]        op;
    logic [data_w:0]   wide;            // carry in the top bit
    logic              carry;
    logic              ovf;
    logic [6:0]        flags_q;         // z c o eq ne gt lt, active high

    assign a = force_x_val_to_zero_n ? x_q : '0;
    assign b = y_q;
    assign op = force_alu_op_to_passx ? alu_pass_x : alu_op;

    always_comb begin
        wide = {1'b0, a};
        ovf = 1'b0;
        case (op)
            alu_add: begin
                wide = {1'b0, a} + {1'b0, b};
                ovf = (a[data_w-1] == b[data_w-1]) && (wide[data_w-1] != a[data_w-1]);
            end
            alu_sub: begin
                wide = {1'b0, a} - {1'b0, b};   // top bit is borrow
                ovf = (a[data_w-1] != b[data_w-1]) && (wide[data_w-1] != a[data_w-1]);
            end
            alu_and: wide = {1'b0, a & b};
            alu_or:  wide = {1'b0, a | b};
            alu_xor: wide = {1'b0, a ^ b};
            alu_inc: begin
                wide = {1'b0, a} + 1'b1;
                ovf = (a == {1'b0, {(data_w - 1){1'b1}}});
            end
            alu_cmp: wide = {a < b, a};         // x unchanged, borrow only
            default: wide = {1'b0, a};          // pass x
        endcase
    end

    assign result = wide[data_w-1:0];
    assign carry = wide[data_w];

    always_ff @(posedge clk) begin
        if (rst) begin
            x_q <= '0;
            y_q <= '0;
            flags_q <= '0;
        end else begin
            if (!reg_in_n) begin
                if (reg_sel)
                    y_q <= bus;
                else
                    x_q <= bus;
            end
            if (!alu_out_n)
                flags_q <= {result == '0, carry, ovf, a == b, a != b, a > b, a < b};
        end
    end

    assign flag_z_n = !flags_q[6];
    assign flag_c_n = !flags_q[5];
    assign flag_o_n = !flags_q[4];
    assign flag_eq_n = !flags_q[3];
    assign flag_ne_n = !flags_q[2];
    assign flag_gt_n = !flags_q[1];
    assign flag_lt_n = !flags_q[0];

endmodule : alu_regs

//--- src/program_counter.sv
`timescale 1ns/1ps
module program_counter
    import cpu_pkg::*;
(
    input  logic               clk,
    input  logic               rst,
    input  logic [data_w-1:0]  bus,
    input  logic               pchitmp_in_n,
    input  logic               pclo_in_n,
    input  logic               pc_in_n,
    output logic [instr_w-1:0] instr
);

    logic [pc_w-1:0]    pc_q;
    logic [data_w-1:0]  hitmp_q;            // high byte staged for a far jump
    logic [instr_w-1:0] rom [rom_depth];

    initial begin
        for (int i = 0; i < rom_depth; i++) begin
            rom[i] = '0;
        end
        $readmemh(rom_file, rom);
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pc_q <= '0;
            hitmp_q <= '0;
        end else begin
            if (!pchitmp_in_n)
                hitmp_q <= bus;
            if (!pc_in_n)
                pc_q <= {hitmp_q, bus};
            else if (!pclo_in_n)
                pc_q <= {pc_q[pc_w-1:data_w], bus};     // keep page
            else
                pc_q <= pc_q + 1'b1;
        end
    end

    assign instr = rom[pc_q[rom_aw-1:0]];   // async read of current word

    // a jump or fall-through past the end of the rom is a program bug
    a_pc_in_rom: assert property (@(posedge clk) disable iff (rst)
        pc_q < rom_depth)
        else $error("program_counter: pc %04h outside rom", pc_q);

endmodule : program_counter

//--- src/control.sv
`timescale 1ns/1ps
module control
    import cpu_pkg::*;
(
    input  logic [7:0] hi_rom,

    input  logic flag_z_n,
    input  logic flag_c_n,
    input  logic flag_o_n,
    input  logic flag_eq_n,
    input  logic flag_ne_n,
    input  logic flag_gt_n,
    input  logic flag_lt_n,
    input  logic uart_in_ready_n,
    input  logic uart_out_ready_n,

    output logic rom_out_n,
    output logic ram_out_n,
    output logic alu_out_n,
    output logic uart_out_n,

    output logic ram_in_n,
    output logic marlo_in_n,
    output logic marhi_in_n,
    output logic uart_in_n,
    output logic pchitmp_in_n,      // high temp reg
    output logic pclo_in_n,         // pc low byte only
    output logic pc_in_n,           // low from bus, high from temp
    output logic reg_in_n,
    output logic reg_sel,

    output logic force_alu_op_to_passx,
    output logic force_x_val_to_zero_n,
    output logic ram_zp_n
);

    logic [2:0] op_sel;
    logic [3:0] dev_code;
    logic       dev_is_reg;
    logic       dev_en;             // device field names a non-register target
    logic       jump_taken;

    assign op_sel = hi_rom[7:5];

    // bus sources
    assign rom_out_n = !(op_sel == op_rom);
    assign ram_out_n = !(op_sel == op_ram || op_sel == op_ram_zp);
    assign alu_out_n = !(op_sel == op_alu || op_sel == op_alu_x0 || op_sel == op_alu_reg);
    assign uart_out_n = !(op_sel == op_uart || op_sel == op_uart_zp);

    // modifiers
    assign ram_zp_n = !(op_sel == op_ram_zp || op_sel == op_alu || op_sel == op_uart_zp);
    assign force_x_val_to_zero_n = !(op_sel == op_alu_x0);
    assign force_alu_op_to_passx = (op_sel == op_alu);

    // register bit is borrowed by the alu op on x0 instructions
    assign dev_is_reg = hi_rom[0] && force_x_val_to_zero_n;
    assign dev_code = hi_rom[4:1];
    assign dev_en = !dev_is_reg;
    assign reg_sel = dev_code[0];   // 0 = x, 1 = y

    assign reg_in_n = !(
        (dev_is_reg && (!rom_out_n || !ram_out_n || !uart_out_n)) ||
        (op_sel == op_alu_reg)
    );

    // zero page alu and uart results also go to ram
    assign ram_in_n = !(
        (dev_en && dev_code == dev_ram) || op_sel == op_alu || op_sel == op_uart_zp
    );
    assign marlo_in_n = !(dev_en && dev_code == dev_marlo);
    assign marhi_in_n = !(dev_en && dev_code == dev_marhi);
    assign uart_in_n = !(dev_en && dev_code == dev_uart);
    assign pchitmp_in_n = !(dev_en && dev_code == dev_pchitmp);
    assign pclo_in_n = !(dev_en && dev_code == dev_pclo);

    // each jump gated by its own flag
    always_comb begin
        jump_taken = 1'b0;
        if (dev_en) begin
            case (dev_code)
                dev_pc:    jump_taken = 1'b1;
                dev_jmpo:  jump_taken = !flag_o_n;
                dev_jmpz:  jump_taken = !flag_z_n;
                dev_jmpc:  jump_taken = !flag_c_n;
                dev_jmpdi: jump_taken = !uart_in_ready_n;   // rx byte waiting
                dev_jmpdo: jump_taken = !uart_out_ready_n;  // tx side free
                dev_jmpeq: jump_taken = !flag_eq_n;
                dev_jmpne: jump_taken = !flag_ne_n;
                dev_jmpgt: jump_taken = !flag_gt_n;
                dev_jmplt: jump_taken = !flag_lt_n;
                default:   jump_taken = 1'b0;
            endcase
        end
    end

    assign pc_in_n = !jump_taken;

    // at most one bus driver, no ram read and write in one word
    always_comb begin
        if (!$isunknown(hi_rom)) begin
            assert ($onehot0({!rom_out_n, !ram_out_n, !alu_out_n, !uart_out_n}))
                else $error("control: more than one bus source for %02h", hi_rom);
            assert (ram_in_n || ram_out_n)
                else $error("control: ram read and write together for %02h", hi_rom);
        end
    end

endmodule : control

//--- src/cpu_pkg.sv
package cpu_pkg;

    // widths
    localparam int data_w = 8;                 // one bus word
    localparam int rom_aw = 8;                 // program address width
    localparam int rom_depth = 1 << rom_aw;
    localparam int instr_w = 2 * data_w;       // control byte + immediate
    localparam int pc_w = 2 * data_w;
    localparam int ram_depth = 256;
    localparam string rom_file = "tb/prog.hex";

    // operation select, bits 7:5 of the control byte
    localparam logic [2:0] op_rom = 3'd0;      // immediate onto bus
    localparam logic [2:0] op_ram = 3'd1;
    localparam logic [2:0] op_ram_zp = 3'd2;
    localparam logic [2:0] op_alu = 3'd3;      // zero page, pass x
    localparam logic [2:0] op_alu_x0 = 3'd4;   // x forced to zero
    localparam logic [2:0] op_alu_reg = 3'd5;  // always loads a reg
    localparam logic [2:0] op_uart = 3'd6;
    localparam logic [2:0] op_uart_zp = 3'd7;

    // device codes, low group
    localparam logic [3:0] dev_ram = 4'd0;
    localparam logic [3:0] dev_marlo = 4'd1;
    localparam logic [3:0] dev_marhi = 4'd2;
    localparam logic [3:0] dev_uart = 4'd3;
    localparam logic [3:0] dev_pchitmp = 4'd4;
    localparam logic [3:0] dev_pclo = 4'd5;
    localparam logic [3:0] dev_pc = 4'd6;
    localparam logic [3:0] dev_jmpo = 4'd7;

    // conditional jumps, high group
    localparam logic [3:0] dev_jmpz = 4'd8;
    localparam logic [3:0] dev_jmpc = 4'd9;
    localparam logic [3:0] dev_jmpdi = 4'd10;
    localparam logic [3:0] dev_jmpdo = 4'd11;
    localparam logic [3:0] dev_jmpeq = 4'd12;
    localparam logic [3:0] dev_jmpne = 4'd13;
    localparam logic [3:0] dev_jmpgt = 4'd14;
    localparam logic [3:0] dev_jmplt = 4'd15;

    // alu ops from the immediate's low nibble
    localparam logic [3:0] alu_pass_x = 4'd0;
    localparam logic [3:0] alu_add = 4'd1;
    localparam logic [3:0] alu_sub = 4'd2;
    localparam logic [3:0] alu_and = 4'd3;
    localparam logic [3:0] alu_or = 4'd4;
    localparam logic [3:0] alu_xor = 4'd5;
    localparam logic [3:0] alu_inc = 4'd6;
    localparam logic [3:0] alu_cmp = 4'd7;

endpackage : cpu_pkg
